// File: project.f
source/dbg_pkg.sv
source/dbg_sticky_flags.sv
source/dbg_event_counter.sv
source/dbg_lane_capture.sv
source/dbg_apb_regs.sv
source/debug_monitor_top.sv
verification/tb_debug_monitor.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run the debug monitor testbench.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f project.f \
  --top-module tb_debug_monitor -o tb_debug_monitor

./obj_dir/tb_debug_monitor 2>&1 | tee sim.log

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "\*\*\* PASSED \*\*\*" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

// File: source/dbg_apb_regs.sv
`timescale 1ns/1ps

module dbg_apb_regs #(
  parameter int          CNT_W           = 48,
  parameter int          NUM_SPARSE_DATA = 12,
  parameter int unsigned BUILD_ID        = 15223003
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dbg_pkg::dbg_paddr_t  paddr_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  dbg_pkg::dbg_word_t   pwdata_i,
  output dbg_pkg::dbg_word_t   prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  output dbg_pkg::dbg_cfg_t    cfg_o,
  output dbg_pkg::dbg_clr_t    clr_o,
  input  dbg_pkg::sticky_vec_t sticky_i,
  input  logic [CNT_W-1:0]     count_i,
  input  dbg_pkg::cap_word_t   cap0_i,
  input  dbg_pkg::cap_word_t   cap1_i
);

  localparam dbg_pkg::probe_addr_t MATCH0_RST = 14'd10;
  localparam dbg_pkg::probe_addr_t MATCH1_RST = 14'd20;

  logic               access;
  logic               mapped;
  logic               wr_ok;
  logic               do_wr;
  logic [63:0]        count_ext;
  dbg_pkg::dbg_word_t rdata;
  dbg_pkg::dbg_cfg_t  cfg_q;
  dbg_pkg::dbg_clr_t  clr_q;

  assign access    = psel_i && penable_i;
  assign count_ext = 64'(count_i);

  // address decode and read mux.
  always_comb begin
    rdata  = '0;
    mapped = 1'b1;
    wr_ok  = 1'b0;
    case (paddr_i)
      dbg_pkg::REG_ID:     rdata = dbg_pkg::dbg_word_t'(BUILD_ID);
      dbg_pkg::REG_CONFIG: rdata = dbg_pkg::dbg_word_t'(NUM_SPARSE_DATA);
      dbg_pkg::REG_STICKY: begin
        rdata = 32'(sticky_i);
        wr_ok = 1'b1; // w1c.
      end
      dbg_pkg::REG_LANE_SEL: begin
        rdata = 32'(cfg_q.lane_sel);
        wr_ok = 1'b1;
      end
      dbg_pkg::REG_MATCH0: begin
        rdata = 32'(cfg_q.match0);
        wr_ok = 1'b1;
      end
      dbg_pkg::REG_MATCH1: begin
        rdata = 32'(cfg_q.match1);
        wr_ok = 1'b1;
      end
      dbg_pkg::REG_CAP0: begin
        rdata = {cap0_i[12], 19'd0, cap0_i[11:0]};
        wr_ok = 1'b1; // any write empties the slot.
      end
      dbg_pkg::REG_CAP1: begin
        rdata = {cap1_i[12], 19'd0, cap1_i[11:0]};
        wr_ok = 1'b1;
      end
      dbg_pkg::REG_CNT_LO: begin
        rdata = count_ext[31:0];
        wr_ok = 1'b1;
      end
      dbg_pkg::REG_CNT_HI: rdata = count_ext[63:32];
      dbg_pkg::REG_FEAT_THRESH: begin
        rdata = 32'(cfg_q.feat_thresh);
        wr_ok = 1'b1;
      end
      default: mapped = 1'b0;
    endcase
  end

  assign do_wr = access && pwrite_i && wr_ok;

  // no wait states, the access phase always completes.
  assign pready_o  = access;
  assign pslverr_o = access && (!mapped || (pwrite_i && !wr_ok));
  assign prdata_o  = (access && !pwrite_i) ? rdata : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q.lane_sel    <= '0;
      cfg_q.match0      <= MATCH0_RST;
      cfg_q.match1      <= MATCH1_RST;
      cfg_q.feat_thresh <= dbg_pkg::FEAT_THRESH_RST;
    end else if (do_wr) begin
      case (paddr_i)
        dbg_pkg::REG_LANE_SEL:    cfg_q.lane_sel    <= dbg_pkg::lane_sel_t'(pwdata_i);
        dbg_pkg::REG_MATCH0:      cfg_q.match0      <= dbg_pkg::probe_addr_t'(pwdata_i);
        dbg_pkg::REG_MATCH1:      cfg_q.match1      <= dbg_pkg::probe_addr_t'(pwdata_i);
        dbg_pkg::REG_FEAT_THRESH: cfg_q.feat_thresh <= dbg_pkg::feat_addr_t'(pwdata_i);
        default: ;
      endcase
    end
  end

  // clear strobes last one cycle, the datapath acts on the following edge.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clr_q <= '0;
    end else begin
      clr_q <= '0;
      if (do_wr) begin
        case (paddr_i)
          dbg_pkg::REG_STICKY: clr_q.sticky_clr <= dbg_pkg::sticky_vec_t'(pwdata_i);
          dbg_pkg::REG_CNT_LO: clr_q.cnt_clr    <= 1'b1;
          dbg_pkg::REG_CAP0:   clr_q.cap_clr[0] <= 1'b1;
          dbg_pkg::REG_CAP1:   clr_q.cap_clr[1] <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  assign cfg_o = cfg_q;
  assign clr_o = clr_q;

endmodule

// File: source/dbg_event_counter.sv
`timescale 1ns/1ps

module dbg_event_counter #(
  parameter int CNT_W = 48
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             inc_i,
  input  logic             clr_i,
  output logic [CNT_W-1:0] count_o
);

  logic [CNT_W-1:0] count_q;

  // free running, wraps at the top.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (clr_i) begin
      count_q <= '0;
    end else if (inc_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

endmodule

// File: source/dbg_lane_capture.sv
`timescale 1ns/1ps

module dbg_lane_capture #(
  parameter int NUM_LANES = 16
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  spmm_rdy_i,
  input  dbg_pkg::probe_addr_t                  probe_addr_i,
  input  dbg_pkg::lane_data_t [NUM_LANES-1:0]   sppe_i,
  input  dbg_pkg::dbg_cfg_t                     cfg_i,
  input  logic [1:0]                            cap_clr_i,
  output dbg_pkg::cap_word_t                    cap0_o,
  output dbg_pkg::cap_word_t                    cap1_o
);

  dbg_pkg::lane_data_t lane;
  logic [1:0]          hit;
  dbg_pkg::cap_word_t  cap_q [2];

  // a lane index past the vector reads as zero.
  assign lane = (cfg_i.lane_sel < NUM_LANES) ? sppe_i[cfg_i.lane_sel] : '0;

  assign hit[0] = spmm_rdy_i && (probe_addr_i == cfg_i.match0);
  assign hit[1] = spmm_rdy_i && (probe_addr_i == cfg_i.match1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2; i++) begin
        cap_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (hit[i]) begin
          cap_q[i] <= {1'b1, lane}; // newest match replaces the old one.
        end else if (cap_clr_i[i]) begin
          cap_q[i] <= '0;
        end
      end
    end
  end

  assign cap0_o = cap_q[0];
  assign cap1_o = cap_q[1];

endmodule

// File: source/dbg_pkg.sv
package dbg_pkg;

  // plain vector widths with a meaning on the bus or the probes.
  typedef logic [31:0] dbg_word_t;   // apb data word.
  typedef logic [7:0]  dbg_paddr_t;  // apb byte address.
  typedef logic [13:0] probe_addr_t; // weight bram probe address.
  typedef logic [15:0] feat_addr_t;  // feature bram address.
  typedef logic [11:0] lane_data_t;  // one sparse pe lane.
  typedef logic [3:0]  lane_sel_t;   // lane index, 16 lanes.

  // stage flags in the low byte, then feature seen and feature above threshold.
  typedef logic [9:0]  sticky_vec_t;

  // capture slot word, valid bit on top of the lane value.
  typedef logic [12:0] cap_word_t;

  // msb first, so the packed image matches the STICKY byte.
  typedef struct packed {
    logic spmm_vld;
    logic spmm_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic sm_vld;
    logic sm_rdy;
    logic aggr_vld;
    logic aggr_rdy;
  } stage_hs_t;

  typedef struct packed {
    logic       en;
    feat_addr_t addr;
  } feat_wr_t;

  typedef struct packed {
    lane_sel_t   lane_sel;
    probe_addr_t match0;
    probe_addr_t match1;
    feat_addr_t  feat_thresh;
  } dbg_cfg_t;

  // single cycle strobes from the register block.
  typedef struct packed {
    sticky_vec_t sticky_clr; // write-one-to-clear mask.
    logic        cnt_clr;
    logic [1:0]  cap_clr;    // one per slot.
  } dbg_clr_t;

  localparam dbg_paddr_t REG_ID          = 8'h00;
  localparam dbg_paddr_t REG_CONFIG      = 8'h04;
  localparam dbg_paddr_t REG_STICKY      = 8'h08;
  localparam dbg_paddr_t REG_LANE_SEL    = 8'h0C;
  localparam dbg_paddr_t REG_MATCH0      = 8'h10;
  localparam dbg_paddr_t REG_MATCH1      = 8'h14;
  localparam dbg_paddr_t REG_CAP0        = 8'h18;
  localparam dbg_paddr_t REG_CAP1        = 8'h1C;
  localparam dbg_paddr_t REG_CNT_LO      = 8'h20;
  localparam dbg_paddr_t REG_CNT_HI      = 8'h24;
  localparam dbg_paddr_t REG_FEAT_THRESH = 8'h28;

  // top of the node feature region.
  localparam feat_addr_t FEAT_THRESH_RST = 16'd43328;

endpackage

// File: source/dbg_sticky_flags.sv
`timescale 1ns/1ps

module dbg_sticky_flags (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dbg_pkg::stage_hs_t   hs_i,
  input  dbg_pkg::feat_wr_t    feat_wr_i,
  input  dbg_pkg::feat_addr_t  feat_thresh_i,
  input  dbg_pkg::sticky_vec_t clr_i,
  output dbg_pkg::sticky_vec_t flags_o
);

  dbg_pkg::sticky_vec_t flags_q;
  dbg_pkg::sticky_vec_t set;
  logic                 feat_seen;
  logic                 feat_high;

  assign feat_seen = feat_wr_i.en;
  assign feat_high = feat_wr_i.en && (feat_wr_i.addr >= feat_thresh_i);

  // event bits line up with the STICKY register.
  assign set = {feat_high, feat_seen, hs_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else begin
      flags_q <= (flags_q & ~clr_i) | set; // set beats clear.
    end
  end

  assign flags_o = flags_q;

endmodule

// File: source/debug_monitor_top.sv
`timescale 1ns/1ps

module debug_monitor_top #(
  parameter int          NUM_SPARSE_DATA = 12,
  parameter int unsigned BUILD_ID        = 15223003,
  parameter int          CNT_W           = 48,
  parameter int          NUM_LANES       = 16
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  dbg_pkg::dbg_paddr_t                 paddr_i,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  dbg_pkg::dbg_word_t                  pwdata_i,
  output dbg_pkg::dbg_word_t                  prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  input  dbg_pkg::stage_hs_t                  hs_i,
  input  dbg_pkg::probe_addr_t                probe_addr_i,
  input  dbg_pkg::lane_data_t [NUM_LANES-1:0] sppe_i,
  input  dbg_pkg::feat_wr_t                   feat_wr_i
);

  dbg_pkg::dbg_cfg_t    cfg;
  dbg_pkg::dbg_clr_t    clr;
  dbg_pkg::sticky_vec_t sticky;
  logic [CNT_W-1:0]     count;
  dbg_pkg::cap_word_t   cap0;
  dbg_pkg::cap_word_t   cap1;

  dbg_apb_regs #(
    .CNT_W           (CNT_W),
    .NUM_SPARSE_DATA (NUM_SPARSE_DATA),
    .BUILD_ID        (BUILD_ID)
  ) u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg_o     (cfg),
    .clr_o     (clr),
    .sticky_i  (sticky),
    .count_i   (count),
    .cap0_i    (cap0),
    .cap1_i    (cap1)
  );

  dbg_sticky_flags u_sticky (
    .clk           (clk),
    .rst_n         (rst_n),
    .hs_i          (hs_i),
    .feat_wr_i     (feat_wr_i),
    .feat_thresh_i (cfg.feat_thresh),
    .clr_i         (clr.sticky_clr),
    .flags_o       (sticky)
  );

  // softmax valid cycles.
  dbg_event_counter #(.CNT_W(CNT_W)) u_counter (
    .clk     (clk),
    .rst_n   (rst_n),
    .inc_i   (hs_i.sm_vld),
    .clr_i   (clr.cnt_clr),
    .count_o (count)
  );

  dbg_lane_capture #(.NUM_LANES(NUM_LANES)) u_capture (
    .clk          (clk),
    .rst_n        (rst_n),
    .spmm_rdy_i   (hs_i.spmm_rdy),
    .probe_addr_i (probe_addr_i),
    .sppe_i       (sppe_i),
    .cfg_i        (cfg),
    .cap_clr_i    (clr.cap_clr),
    .cap0_o       (cap0),
    .cap1_o       (cap1)
  );

endmodule

// File: verification/tb_debug_monitor.sv
`timescale 1ns/1ps

module tb_debug_monitor;

  localparam int TIMEOUT = 16;

  logic                       clk;
  logic                       rst_n;
  dbg_pkg::dbg_paddr_t        paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  dbg_pkg::dbg_word_t         pwdata;
  dbg_pkg::dbg_word_t         prdata;
  logic                       pready;
  logic                       pslverr;
  dbg_pkg::stage_hs_t         hs;
  dbg_pkg::probe_addr_t       probe_addr;
  dbg_pkg::lane_data_t [15:0] sppe;
  dbg_pkg::feat_wr_t          feat_wr;

  // reference model state.
  logic [9:0]  m_sticky;
  logic [47:0] m_cnt;
  logic [12:0] m_cap [2];
  logic [3:0]  m_lane_sel;
  logic [13:0] m_match [2];
  logic [15:0] m_thresh;
  logic [9:0]  pend_sticky; // clear strobes reach the datapath one edge late.
  logic        pend_cnt;
  logic [1:0]  pend_cap;

  int seed = 54;
  int errors = 0;
  int checks = 0;

  debug_monitor_top u_debug_monitor_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .paddr_i      (paddr),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr),
    .hs_i         (hs),
    .probe_addr_i (probe_addr),
    .sppe_i       (sppe),
    .feat_wr_i    (feat_wr)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin : ref_model
    logic [11:0] lane;
    logic [1:0]  hit;
    if (!rst_n) begin
      m_sticky    = '0;
      m_cnt       = '0;
      m_cap[0]    = '0;
      m_cap[1]    = '0;
      m_lane_sel  = '0;
      m_match[0]  = 14'd10;
      m_match[1]  = 14'd20;
      m_thresh    = 16'd43328;
      pend_sticky = '0;
      pend_cnt    = 1'b0;
      pend_cap    = '0;
    end else begin
      lane   = sppe[m_lane_sel];
      hit[0] = hs.spmm_rdy && (probe_addr == m_match[0]);
      hit[1] = hs.spmm_rdy && (probe_addr == m_match[1]);
      m_sticky = (m_sticky & ~pend_sticky) |
                 {feat_wr.en && (feat_wr.addr >= m_thresh), feat_wr.en, hs};
      if (pend_cnt) begin
        m_cnt = '0;
      end else if (hs.sm_vld) begin
        m_cnt = m_cnt + 48'd1;
      end
      for (int i = 0; i < 2; i++) begin
        if (hit[i]) begin
          m_cap[i] = {1'b1, lane};
        end else if (pend_cap[i]) begin
          m_cap[i] = '0;
        end
      end
      pend_sticky = '0;
      pend_cnt    = 1'b0;
      pend_cap    = '0;
      if (psel && penable && pwrite) begin
        case (paddr)
          dbg_pkg::REG_STICKY:      pend_sticky = pwdata[9:0];
          dbg_pkg::REG_CNT_LO:      pend_cnt    = 1'b1;
          dbg_pkg::REG_CAP0:        pend_cap[0] = 1'b1;
          dbg_pkg::REG_CAP1:        pend_cap[1] = 1'b1;
          dbg_pkg::REG_LANE_SEL:    m_lane_sel  = pwdata[3:0];
          dbg_pkg::REG_MATCH0:      m_match[0]  = pwdata[13:0];
          dbg_pkg::REG_MATCH1:      m_match[1]  = pwdata[13:0];
          dbg_pkg::REG_FEAT_THRESH: m_thresh    = pwdata[15:0];
          default: ;
        endcase
      end
    end
  end

  function automatic dbg_pkg::dbg_word_t ref_read(input dbg_pkg::dbg_paddr_t offset);
    case (offset)
      dbg_pkg::REG_ID:          return 32'd15223003;
      dbg_pkg::REG_CONFIG:      return 32'd12;
      dbg_pkg::REG_STICKY:      return {22'd0, m_sticky};
      dbg_pkg::REG_LANE_SEL:    return {28'd0, m_lane_sel};
      dbg_pkg::REG_MATCH0:      return {18'd0, m_match[0]};
      dbg_pkg::REG_MATCH1:      return {18'd0, m_match[1]};
      dbg_pkg::REG_CAP0:        return {m_cap[0][12], 19'd0, m_cap[0][11:0]};
      dbg_pkg::REG_CAP1:        return {m_cap[1][12], 19'd0, m_cap[1][11:0]};
      dbg_pkg::REG_CNT_LO:      return m_cnt[31:0];
      dbg_pkg::REG_CNT_HI:      return {16'd0, m_cnt[47:32]};
      dbg_pkg::REG_FEAT_THRESH: return {16'd0, m_thresh};
      default:                  return '0;
    endcase
  endfunction

  // unmapped offsets and writes to read-only registers answer with pslverr.
  function automatic logic ref_err(input dbg_pkg::dbg_paddr_t offset, input logic wr);
    case (offset)
      dbg_pkg::REG_ID, dbg_pkg::REG_CONFIG, dbg_pkg::REG_CNT_HI: return wr;
      dbg_pkg::REG_STICKY, dbg_pkg::REG_LANE_SEL, dbg_pkg::REG_MATCH0,
      dbg_pkg::REG_MATCH1, dbg_pkg::REG_CAP0, dbg_pkg::REG_CAP1,
      dbg_pkg::REG_CNT_LO, dbg_pkg::REG_FEAT_THRESH: return 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  task automatic check(input string what, input dbg_pkg::dbg_word_t exp,
                       input dbg_pkg::dbg_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, what, exp, act);
    end
  endtask

  task automatic finish_run;
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic step;
    @(posedge clk);
    #1;
  endtask

  task automatic probes_idle;
    hs         = '0;
    probe_addr = '0;
    sppe       = '0;
    feat_wr    = '0;
  endtask

  // one setup phase and an access phase held until pready.
  task automatic bus_cycle(input logic wr, input dbg_pkg::dbg_paddr_t addr,
                           input dbg_pkg::dbg_word_t wdata, output dbg_pkg::dbg_word_t rdata,
                           output logic err, output dbg_pkg::dbg_word_t exp_rd);
    int n;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    step();
    penable = 1'b1;
    #1;
    n = 0;
    while (!pready && n < TIMEOUT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!pready) begin
      $display("timeout: pready did not rise within %0d cycles at offset %h", TIMEOUT, addr);
      errors++;
      finish_run();
    end else begin
      check($sformatf("wait states at offset %h", addr), 32'd0, 32'(n));
      rdata  = prdata;
      err    = pslverr;
      exp_rd = ref_read(addr);
      step();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
    end
  endtask

  task automatic apb_write(input dbg_pkg::dbg_paddr_t addr, input dbg_pkg::dbg_word_t data);
    dbg_pkg::dbg_word_t rd;
    dbg_pkg::dbg_word_t exp;
    logic               err;
    bus_cycle(1'b1, addr, data, rd, err, exp);
    check($sformatf("pslverr on write to %h", addr), {31'd0, ref_err(addr, 1'b1)}, {31'd0, err});
  endtask

  task automatic read_check(input dbg_pkg::dbg_paddr_t addr);
    dbg_pkg::dbg_word_t rd;
    dbg_pkg::dbg_word_t exp;
    logic               err;
    bus_cycle(1'b0, addr, '0, rd, err, exp);
    check($sformatf("read of offset %h", addr), exp, rd);
    check($sformatf("pslverr on read of %h", addr), {31'd0, ref_err(addr, 1'b0)}, {31'd0, err});
  endtask

  initial begin : stimulus
    int n;
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    probes_idle();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();

    check("pready while idle after reset", 32'd0, {31'd0, pready});
    check("pslverr while idle after reset", 32'd0, {31'd0, pslverr});
    check("prdata while idle after reset", 32'd0, prdata);

    for (int a = 0; a <= 8'h28; a += 4) begin
      read_check(dbg_pkg::dbg_paddr_t'(a)); // reset values.
    end
    read_check(8'h2C);
    read_check(8'h03);
    apb_write(dbg_pkg::REG_ID, 32'h1234);
    apb_write(dbg_pkg::REG_CNT_HI, 32'h1);
    read_check(dbg_pkg::REG_ID);

    repeat (40) begin
      if (($random(seed) & 3) == 0) begin
        hs = dbg_pkg::stage_hs_t'(8'h01 << ($random(seed) & 7));
      end else begin
        hs = '0;
      end
      step();
    end
    probes_idle();
    read_check(dbg_pkg::REG_STICKY);
    hs = dbg_pkg::stage_hs_t'(8'hFF);
    step();
    probes_idle();
    apb_write(dbg_pkg::REG_STICKY, 32'h0A5);
    read_check(dbg_pkg::REG_STICKY);
    apb_write(dbg_pkg::REG_STICKY, 32'h0FF);
    hs = dbg_pkg::stage_hs_t'(8'h04); // lands with the clear strobe.
    step();
    probes_idle();
    read_check(dbg_pkg::REG_STICKY);

    apb_write(dbg_pkg::REG_FEAT_THRESH, 32'h8000);
    read_check(dbg_pkg::REG_FEAT_THRESH);
    for (int i = 0; i < 6; i++) begin
      apb_write(dbg_pkg::REG_STICKY, 32'h300);
      step();
      feat_wr.en = 1'b1;
      case (i)
        0: feat_wr.addr = 16'h7FFF;
        1: feat_wr.addr = 16'h8000;
        2: feat_wr.addr = 16'hC123;
        default: feat_wr.addr = dbg_pkg::feat_addr_t'($random(seed));
      endcase
      step();
      probes_idle();
      read_check(dbg_pkg::REG_STICKY);
    end

    apb_write(dbg_pkg::REG_CNT_LO, 32'h0);
    n = ($random(seed) & 63) + 20;
    repeat (n) begin
      hs.sm_vld = 1'($random(seed));
      step();
    end
    probes_idle();
    read_check(dbg_pkg::REG_CNT_LO);
    read_check(dbg_pkg::REG_CNT_HI);
    apb_write(dbg_pkg::REG_CNT_LO, 32'hFFFF);
    read_check(dbg_pkg::REG_CNT_LO);

    apb_write(dbg_pkg::REG_LANE_SEL, 32'd5);
    apb_write(dbg_pkg::REG_MATCH0, 32'd100);
    apb_write(dbg_pkg::REG_MATCH1, 32'd103);
    read_check(dbg_pkg::REG_LANE_SEL);
    read_check(dbg_pkg::REG_MATCH0);
    read_check(dbg_pkg::REG_MATCH1);
    for (int i = 0; i < 48; i++) begin
      probe_addr  = dbg_pkg::probe_addr_t'(98 + (i % 9)); // sweep across both matches.
      hs.spmm_rdy = 1'($random(seed));
      for (int l = 0; l < 16; l++) begin
        sppe[l] = dbg_pkg::lane_data_t'($random(seed));
      end
      step();
    end
    probes_idle();
    read_check(dbg_pkg::REG_CAP0);
    read_check(dbg_pkg::REG_CAP1);

    apb_write(dbg_pkg::REG_CAP0, 32'h1);
    read_check(dbg_pkg::REG_CAP0);
    probe_addr = 14'd100;
    sppe[5]    = 12'hABC;
    step();
    probes_idle();
    read_check(dbg_pkg::REG_CAP0);

    apb_write(dbg_pkg::REG_LANE_SEL, 32'($random(seed) & 15));
    apb_write(dbg_pkg::REG_CAP1, 32'h0);
    read_check(dbg_pkg::REG_CAP1);
    probe_addr  = 14'd103;
    hs.spmm_rdy = 1'b1;
    for (int l = 0; l < 16; l++) begin
      sppe[l] = dbg_pkg::lane_data_t'($random(seed));
    end
    step();
    probes_idle();
    read_check(dbg_pkg::REG_CAP1);
    read_check(dbg_pkg::REG_LANE_SEL);
    read_check(dbg_pkg::REG_STICKY);

    finish_run();
  end

endmodule
